// ==== int_div_pkg.sv ====
// ------------------------------
// int div package
// shared widths, depths and types for the divide unit
// ------------------------------

package int_div_pkg;

  // operand width
  localparam int DATA_W = 32;
  // remainder/quotient register, one guard bit on top
  localparam int ACC_W = 2 * DATA_W + 1;
  // iteration counter, counts DATA_W-1 down to 0
  localparam int CNT_W = 5;

  // request queue depth, also the initial input credit count
  localparam int REQ_DEPTH = 4;
  localparam int REQ_PTR_W = $clog2(REQ_DEPTH);
  localparam int REQ_CNT_W = $clog2(REQ_DEPTH + 1);

  // receiver buffer size seen by the sender
  localparam int RESP_CREDITS = 2;
  localparam int CREDIT_W = $clog2(RESP_CREDITS + 1);

  typedef logic [DATA_W-1:0] div_word_t;

  typedef enum logic {
    DIV_UNSIGNED = 1'b0,
    DIV_SIGNED   = 1'b1
  } div_op_e;

  typedef enum logic [1:0] {
    IDLE,
    CALC,
    DONE
  } div_state_e;

endpackage

// ==== int_div_ifs.sv ====
// ------------------------------
// divide unit interfaces
// request, response and divider control bundles
// ------------------------------

`timescale 1ns/1ps

// request from the queue into the divider
interface div_req_if import int_div_pkg::*; ();
  logic      valid;
  div_op_e   op;
  div_word_t a;
  div_word_t b;
  logic      ready;

  // queue side
  modport src (output valid, output op, output a, output b, input ready);
  // divider side, ctrl owns ready and dpath only reads the data
  modport dst (input valid, input op, input a, input b, output ready);
endinterface

// result from the divider toward the sender
interface div_resp_if import int_div_pkg::*; ();
  logic      valid;
  div_word_t quotient;
  div_word_t remainder;
  logic      ready;

  // handshake half, driven by the controller
  modport ctrl (output valid, input ready);
  // payload half, driven by the datapath
  modport data (output quotient, output remainder);
  // sender side
  modport dst (input valid, input quotient, input remainder, output ready);
endinterface

// controller <-> datapath wiring
interface div_ctrl_if ();
  // register enables and mux selects
  logic a_en;
  logic b_en;
  logic a_sel;
  logic sub_sel;
  logic cnt_load;
  logic sign_en;
  logic op_signed;
  // status back from the datapath
  logic sub_neg;
  logic cnt_zero;

  modport ctrl (
    output a_en, output b_en, output a_sel, output sub_sel,
    output cnt_load, output sign_en, output op_signed,
    input  sub_neg, input cnt_zero
  );

  modport dpath (
    input  a_en, input b_en, input a_sel, input sub_sel,
    input  cnt_load, input sign_en, input op_signed,
    output sub_neg, output cnt_zero
  );
endinterface

// ==== div_req_buffer.sv ====
// ------------------------------
// divide request buffer
// circular request queue, one credit back per dequeue
// ------------------------------

`timescale 1ns/1ps

module div_req_buffer import int_div_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      in_valid,
  input  div_op_e   in_op,
  input  div_word_t in_a,
  input  div_word_t in_b,
  output logic      in_credit,
  div_req_if.src    req
);

  // entry storage, no reset needed
  div_op_e   op_mem [REQ_DEPTH];
  div_word_t a_mem  [REQ_DEPTH];
  div_word_t b_mem  [REQ_DEPTH];

  logic [REQ_PTR_W-1:0] wr_ptr;
  logic [REQ_PTR_W-1:0] rd_ptr;
  logic [REQ_CNT_W-1:0] count;
  logic                 push;
  logic                 pop;

  // a push into a full queue is a sender error and is dropped
  assign push = in_valid && (count != REQ_CNT_W'(REQ_DEPTH));
  assign pop  = req.valid && req.ready;

  // head entry is always on the interface
  assign req.valid = (count != '0);
  assign req.op    = op_mem[rd_ptr];
  assign req.a     = a_mem[rd_ptr];
  assign req.b     = b_mem[rd_ptr];

  // credit goes back in the dequeue cycle itself
  assign in_credit = pop;

  // ------------------------------
  // pointers and occupancy
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // depth is a power of two so the pointers wrap on their own
      if (push) begin
        wr_ptr <= wr_ptr + REQ_PTR_W'(1);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + REQ_PTR_W'(1);
      end
      case ({push, pop})
        2'b10:   count <= count + REQ_CNT_W'(1);
        2'b01:   count <= count - REQ_CNT_W'(1);
        default: count <= count;
      endcase
    end
  end

  // write port, entry shows up at the head one cycle later
  always_ff @(posedge clk) begin
    if (push) begin
      op_mem[wr_ptr] <= in_op;
      a_mem[wr_ptr]  <= in_a;
      b_mem[wr_ptr]  <= in_b;
    end
  end

endmodule

// ==== int_div_ctrl.sv ====
// ------------------------------
// divider control
// IDLE/CALC/DONE FSM driving the shift-subtract datapath
// ------------------------------

`timescale 1ns/1ps

module int_div_ctrl import int_div_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  div_req_if.dst    req,
  div_resp_if.ctrl  resp,
  div_ctrl_if.ctrl  ctl
);

  div_state_e state;
  div_state_e state_next;
  logic       ready_q;
  logic       accept;
  logic       deliver;

  // ready_q is only high in IDLE, so it also qualifies the accept
  assign accept  = req.valid && req.ready;
  assign deliver = resp.valid && resp.ready;

  assign req.ready  = ready_q;
  // result holds in DONE until the sender takes it
  assign resp.valid = (state == DONE);

  // opcode decode feeds normalization and sign latching
  assign ctl.op_signed = (req.op == DIV_SIGNED);

  // ------------------------------
  // state register
  // ------------------------------
  always_comb begin
    state_next = state;
    case (state)
      IDLE: if (accept) state_next = CALC;
      // last iteration runs in the cnt_zero cycle
      CALC: if (ctl.cnt_zero) state_next = DONE;
      DONE: if (deliver) state_next = IDLE;
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= IDLE;
      ready_q <= 1'b0;
    end else begin
      state   <= state_next;
      // registered ready, comes up one cycle after reset
      ready_q <= (state_next == IDLE);
    end
  end

  // ------------------------------
  // datapath controls
  // ------------------------------
  always_comb begin
    ctl.a_en     = 1'b0;
    ctl.b_en     = 1'b0;
    ctl.a_sel    = 1'b0;
    ctl.sub_sel  = 1'b0;
    ctl.sign_en  = 1'b0;
    // counter parks at its start value outside CALC
    ctl.cnt_load = 1'b1;
    case (state)
      IDLE: begin
        // load operands, divisor and signs on the accept
        ctl.a_en    = accept;
        ctl.b_en    = accept;
        ctl.sign_en = accept;
      end
      CALC: begin
        // shift every cycle, restore when the trial went negative
        ctl.a_en     = 1'b1;
        ctl.a_sel    = 1'b1;
        ctl.sub_sel  = ctl.sub_neg;
        ctl.cnt_load = 1'b0;
      end
      default: begin
        // DONE holds everything steady
      end
    endcase
  end

endmodule

// ==== int_div_dpath.sv ====
// ------------------------------
// divider datapath
// restoring shift-subtract with sign and zero-divisor fix-up
// ------------------------------

`timescale 1ns/1ps

module int_div_dpath import int_div_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  div_req_if.dst    req,
  div_resp_if.data  resp,
  div_ctrl_if.dpath ctl
);

  // operand magnitudes and the selected start values
  div_word_t mag_a;
  div_word_t mag_b;
  div_word_t norm_a;
  div_word_t norm_b;

  // shift-subtract path
  logic [ACC_W-1:0] acc_init;
  logic [ACC_W-1:0] div_init;
  logic [ACC_W-1:0] acc_shift;
  logic [ACC_W-1:0] sub_out;
  logic [ACC_W-1:0] sub_keep;
  logic [ACC_W-1:0] sub_restore;
  logic [ACC_W-1:0] acc_next;

  // state of the running divide
  logic [ACC_W-1:0] acc_reg;
  logic [ACC_W-1:0] div_reg;
  logic [CNT_W-1:0] cnt_reg;
  logic             q_neg;
  logic             r_neg;
  logic             b_zero;
  div_word_t        a_orig;

  // result assembly
  div_word_t quot_raw;
  div_word_t rem_raw;
  div_word_t quot_fix;
  div_word_t rem_fix;

  // ------------------------------
  // operand normalization
  // ------------------------------
  assign mag_a  = req.a[DATA_W-1] ? (~req.a + 1'b1) : req.a;
  assign mag_b  = req.b[DATA_W-1] ? (~req.b + 1'b1) : req.b;
  assign norm_a = ctl.op_signed ? mag_a : req.a;
  assign norm_b = ctl.op_signed ? mag_b : req.b;

  // dividend in the low half, divisor aligned to the high half
  assign acc_init = {{(DATA_W + 1){1'b0}}, norm_a};
  assign div_init = {1'b0, norm_b, {DATA_W{1'b0}}};

  // ------------------------------
  // one restoring step
  // ------------------------------
  assign acc_shift   = acc_reg << 1;
  assign sub_out     = acc_shift - div_reg;
  // guard bit set means the trial subtract underflowed
  assign ctl.sub_neg = sub_out[ACC_W-1];
  assign sub_keep    = {sub_out[ACC_W-1:1], 1'b1};
  assign sub_restore = {acc_shift[ACC_W-1:1], 1'b0};
  assign acc_next    = ctl.a_sel ? (ctl.sub_sel ? sub_restore : sub_keep) : acc_init;

  assign ctl.cnt_zero = (cnt_reg == '0);

  // iteration counter, reloads whenever ctrl is not in CALC
  always_ff @(posedge clk) begin
    if (reset) begin
      cnt_reg <= '0;
    end else if (ctl.cnt_load) begin
      cnt_reg <= CNT_W'(DATA_W - 1);
    end else begin
      cnt_reg <= cnt_reg - CNT_W'(1);
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (ctl.a_en) begin
      acc_reg <= acc_next;
    end
    if (ctl.b_en) begin
      div_reg <= div_init;
    end
    if (ctl.sign_en) begin
      // quotient sign is the xor of operand signs, remainder follows the dividend
      q_neg  <= ctl.op_signed & (req.a[DATA_W-1] ^ req.b[DATA_W-1]);
      r_neg  <= ctl.op_signed & req.a[DATA_W-1];
      b_zero <= (req.b == '0);
      a_orig <= req.a;
    end
  end

  // ------------------------------
  // sign fix-up and special cases
  // ------------------------------
  assign quot_raw = acc_reg[DATA_W-1:0];
  assign rem_raw  = acc_reg[2*DATA_W-1:DATA_W];
  assign quot_fix = q_neg ? (~quot_raw + 1'b1) : quot_raw;
  assign rem_fix  = r_neg ? (~rem_raw + 1'b1) : rem_raw;

  // MIN / -1 lands on quotient == dividend, remainder 0 without extra logic
  assign resp.quotient  = b_zero ? '1 : quot_fix;
  assign resp.remainder = b_zero ? a_orig : rem_fix;

endmodule

// ==== div_resp_sender.sv ====
// ------------------------------
// response sender
// one-entry output register gated by receiver credits
// ------------------------------

`timescale 1ns/1ps

module div_resp_sender import int_div_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  div_resp_if.dst   resp,
  input  logic      out_credit,
  output logic      out_valid,
  output div_word_t out_quotient,
  output div_word_t out_remainder
);

  logic                full;
  logic                take;
  logic                send;
  logic [CREDIT_W-1:0] credits;
  div_word_t           quot_q;
  div_word_t           rem_q;

  // back-pressure into the divider while the register is occupied
  assign resp.ready = ~full;
  assign take       = resp.valid && resp.ready;

  // go out as soon as a result sits here and a credit is available
  assign send = full && (credits != '0);

  assign out_valid     = send;
  assign out_quotient  = quot_q;
  assign out_remainder = rem_q;

  // ------------------------------
  // occupancy and credit count
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      full    <= 1'b0;
      credits <= CREDIT_W'(RESP_CREDITS);
    end else begin
      // take and send never coincide since ready is low while full
      if (take) begin
        full <= 1'b1;
      end else if (send) begin
        full <= 1'b0;
      end
      // returned credit and a send in the same cycle cancel out
      case ({out_credit, send})
        2'b10:   credits <= credits + CREDIT_W'(1);
        2'b01:   credits <= credits - CREDIT_W'(1);
        default: credits <= credits;
      endcase
    end
  end

  // result payload
  always_ff @(posedge clk) begin
    if (take) begin
      quot_q <= resp.quotient;
      rem_q  <= resp.remainder;
    end
  end

endmodule

// ==== int_div_unit.sv ====
// ------------------------------
// int divide unit top
// credit-flow buffer, iterative divider and sender
// ------------------------------

`timescale 1ns/1ps

module int_div_unit import int_div_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  // request side, credit based
  input  logic      in_valid,
  input  div_op_e   in_op,
  input  div_word_t in_a,
  input  div_word_t in_b,
  output logic      in_credit,
  // result side, credit based
  output logic      out_valid,
  output div_word_t out_quotient,
  output div_word_t out_remainder,
  input  logic      out_credit
);

  // internal ready/valid links
  div_req_if  req_if ();
  div_resp_if resp_if ();
  div_ctrl_if ctl_if ();

  // input queue
  div_req_buffer u_req_buffer (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_op     (in_op),
    .in_a      (in_a),
    .in_b      (in_b),
    .in_credit (in_credit),
    .req       (req_if.src)
  );

  // divider, control half
  int_div_ctrl u_ctrl (
    .clk   (clk),
    .reset (reset),
    .req   (req_if.dst),
    .resp  (resp_if.ctrl),
    .ctl   (ctl_if.ctrl)
  );

  // divider, datapath half
  int_div_dpath u_dpath (
    .clk   (clk),
    .reset (reset),
    .req   (req_if.dst),
    .resp  (resp_if.data),
    .ctl   (ctl_if.dpath)
  );

  // output stage
  div_resp_sender u_resp_sender (
    .clk           (clk),
    .reset         (reset),
    .resp          (resp_if.dst),
    .out_credit    (out_credit),
    .out_valid     (out_valid),
    .out_quotient  (out_quotient),
    .out_remainder (out_remainder)
  );

endmodule

// ==== tb_int_div_unit.sv ====
// ------------------------------
// int divide unit testbench
// credit driver and receiver checked against a test file
// ------------------------------

`timescale 1ns/1ps

module tb_int_div_unit import int_div_pkg::*; ();

  // each test is five hex words of op a b quotient remainder
  localparam int TEST_WORDS      = 5;
  localparam int MEM_WORDS       = 256;
  localparam int MEM_AW          = 8;
  localparam int MAX_TESTS       = MEM_WORDS / TEST_WORDS;
  localparam int CYCLES_PER_TEST = 60;
  // receiver sits on its credits for a while after this many results
  localparam int HOLD_AFTER      = 4;
  localparam int HOLD_CYCLES     = 150;

  logic      clk;
  logic      reset;
  logic      in_valid;
  div_op_e   in_op;
  div_word_t in_a;
  div_word_t in_b;
  logic      in_credit;
  logic      out_valid;
  div_word_t out_quotient;
  div_word_t out_remainder;
  logic      out_credit;

  logic [31:0] test_mem [MEM_WORDS];
  int          num_tests;
  logic        tests_loaded;
  // credit return delay of 0 to 8 cycles per result
  int          delay_tab [$];
  int          rand_init;

  // driver bookkeeping
  int next_idx;
  int in_credits;
  // receiver bookkeeping
  int rx_idx;
  int credits_back;
  int hold_left;
  int credit_delays [$];

  int_div_unit dut (
    .clk           (clk),
    .reset         (reset),
    .in_valid      (in_valid),
    .in_op         (in_op),
    .in_a          (in_a),
    .in_b          (in_b),
    .in_credit     (in_credit),
    .out_valid     (out_valid),
    .out_quotient  (out_quotient),
    .out_remainder (out_remainder),
    .out_credit    (out_credit)
  );

  // ------------------------------
  // helpers
  // ------------------------------
  function automatic logic [31:0] test_word(input int t, input int k);
    return test_mem[MEM_AW'(TEST_WORDS * t + k)];
  endfunction

  task automatic end_with_failure();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic report_error(input string what);
    $display("ERROR at %0t ns: %s", $time, what);
    end_with_failure();
  endtask

  task automatic check_quotient(input int idx, input div_word_t expected,
                                input div_word_t actual);
    if (actual !== expected) begin
      $display("[FAIL] %0t ns out_quotient test %0d expected %h actual %h",
               $time, idx, expected, actual);
      end_with_failure();
    end
  endtask

  task automatic check_remainder(input int idx, input div_word_t expected,
                                 input div_word_t actual);
    if (actual !== expected) begin
      $display("[FAIL] %0t ns out_remainder test %0d expected %h actual %h",
               $time, idx, expected, actual);
      end_with_failure();
    end
  endtask

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ------------------------------
  // setup, reset and end of run
  // ------------------------------
  initial begin
    reset        = 1'b1;
    in_valid     = 1'b0;
    in_op        = DIV_UNSIGNED;
    in_a         = '0;
    in_b         = '0;
    out_credit   = 1'b0;
    tests_loaded = 1'b0;
    rand_init    = $urandom(32'hda9e);
    // fill follows the address and never reads as a valid op word
    for (int i = 0; i < MEM_WORDS; i++) begin
      test_mem[MEM_AW'(i)] = ~32'(i);
    end
    $readmemh("int_div_tests.txt", test_mem);
    num_tests = 0;
    while (num_tests < MAX_TESTS && test_word(num_tests, 0) inside {32'd0, 32'd1}) begin
      num_tests = num_tests + 1;
    end
    if (num_tests == 0) begin
      report_error("no tests found in int_div_tests.txt");
    end
    for (int i = 0; i < num_tests; i++) begin
      delay_tab.push_back(int'($urandom % 9));
    end
    tests_loaded = 1'b1;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    wait (rx_idx == num_tests);
    // linger so a stray extra result or a late credit still gets caught
    repeat (40) @(posedge clk);
    if (next_idx != num_tests || in_credits != REQ_DEPTH) begin
      report_error($sformatf("run ended with %0d requests sent and %0d input credits held",
                             next_idx, in_credits));
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

  // watchdog scaled to the number of tests
  initial begin : watchdog
    wait (tests_loaded);
    repeat (10 + num_tests * CYCLES_PER_TEST) @(posedge clk);
    report_error($sformatf("timeout with %0d of %0d results received", rx_idx, num_tests));
  end

  // ------------------------------
  // request driver
  // ------------------------------
  always @(posedge clk) begin : drive_requests
    int          credits_now;
    logic [31:0] op_word;
    if (reset) begin
      next_idx   <= 0;
      in_credits <= REQ_DEPTH;
      in_valid   <= 1'b0;
    end else begin
      credits_now = in_credits;
      // the dequeue behind this credit frees its slot at this edge
      if (in_credit) begin
        credits_now = credits_now + 1;
      end
      if (credits_now > REQ_DEPTH) begin
        report_error("in_credit returned more credits than requests sent");
      end
      in_valid <= 1'b0;
      if (next_idx < num_tests && credits_now > 0) begin
        op_word     = test_word(next_idx, 0);
        in_valid    <= 1'b1;
        in_op       <= op_word[0] ? DIV_SIGNED : DIV_UNSIGNED;
        in_a        <= test_word(next_idx, 1);
        in_b        <= test_word(next_idx, 2);
        next_idx    <= next_idx + 1;
        credits_now = credits_now - 1;
      end
      in_credits <= credits_now;
    end
  end

  // ------------------------------
  // result receiver
  // ------------------------------
  always @(posedge clk) begin : receive_results
    int          avail;
    logic [31:0] exp_q;
    logic [31:0] exp_r;
    if (reset) begin
      rx_idx       = 0;
      credits_back = 0;
      hold_left    = 0;
      credit_delays.delete();
      out_credit   <= 1'b0;
    end else begin
      // sender credit count before this edge
      avail = RESP_CREDITS + credits_back - rx_idx;
      if (out_valid) begin
        if (avail <= 0) begin
          report_error("out_valid rose while the sender held no credits");
        end
        if (rx_idx >= num_tests) begin
          report_error("result arrived with no request outstanding");
        end
        exp_q = test_word(rx_idx, 3);
        exp_r = test_word(rx_idx, 4);
        check_quotient(rx_idx, exp_q, out_quotient);
        check_remainder(rx_idx, exp_r, out_remainder);
        credit_delays.push_back(delay_tab[rx_idx]);
        rx_idx = rx_idx + 1;
        // starve the sender so the stall reaches back to the queue
        if (rx_idx == HOLD_AFTER) begin
          hold_left = HOLD_CYCLES;
        end
      end
      if (out_credit) begin
        credits_back = credits_back + 1;
      end
      // at most one credit pulse per cycle
      out_credit <= 1'b0;
      if (hold_left > 0) begin
        hold_left = hold_left - 1;
      end else if (credit_delays.size() > 0) begin
        if (credit_delays[0] == 0) begin
          out_credit <= 1'b1;
          void'(credit_delays.pop_front());
        end else begin
          credit_delays[0] = credit_delays[0] - 1;
        end
      end
    end
  end

endmodule

// ==== int_div_unit.f ====
int_div_pkg.sv
int_div_ifs.sv
div_req_buffer.sv
int_div_ctrl.sv
int_div_dpath.sv
div_resp_sender.sv
int_div_unit.sv
tb_int_div_unit.sv

// ==== Makefile ====
# Verilator build and run for the integer divide unit testbench

VERILATOR ?= verilator
TOP       ?= tb_int_div_unit
FILELIST  ?= int_div_unit.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

# every source named in the file list, so an edit triggers a rebuild
SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

# exit status of the simulator is the test result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== int_div_tests.txt ====
// columns, all hex: op (0 unsigned, 1 signed) dividend divisor quotient remainder
// divide by zero gives all ones and the dividend, MIN / -1 gives the dividend and zero
0 00000064 00000007 0000000e 00000002
0 00000003 0000000a 00000000 00000003
0 ffffffff 00000001 ffffffff 00000000
0 ffffffff ffffffff 00000001 00000000
0 ffffffff 00000010 0fffffff 0000000f
0 80000000 00000003 2aaaaaaa 00000002
0 12345678 00001000 00012345 00000678
0 00000000 00000005 00000000 00000000
0 deadbeef 00010000 0000dead 0000beef
0 80000000 ffffffff 00000000 80000000
0 00000001 00000001 00000001 00000000
1 00000064 00000007 0000000e 00000002
1 ffffff9c 00000007 fffffff2 fffffffe
1 00000064 fffffff9 fffffff2 00000002
1 ffffff9c fffffff9 0000000e fffffffe
1 00000007 ffffff9c 00000000 00000007
1 fffffff9 00000064 00000000 fffffff9
1 80000000 ffffffff 80000000 00000000
1 80000000 00000001 80000000 00000000
1 80000000 00000002 c0000000 00000000
1 7fffffff 80000000 00000000 7fffffff
1 ffffffff ffffffff 00000001 00000000
1 fffffff8 00000002 fffffffc 00000000
0 12345678 00000000 ffffffff 12345678
1 ffffff9c 00000000 ffffffff ffffff9c
1 00000000 00000000 ffffffff 00000000
